//--- spi_dma_top.f
+incdir+.
spi_dma_pkg.sv
spi_xfer_if.sv
xfer_buf_ram.sv
spi_master.sv
spi_xfer_ctrl.sv
spi_dma_top.sv
spi_dma_assert.sv
spi_dma_tb.sv

//--- Makefile
SIM  := obj_dir/Vspi_dma_tb
SRCS := $(shell grep -v '^+' spi_dma_top.f) spi_dma_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) spi_dma_top.f
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module spi_dma_tb -f spi_dma_top.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- spi_dma_tb.sv
`timescale 1ns/1ns
`include "spi_dma_macros.svh"

module spi_dma_tb;

    localparam int DONE_LIMIT = 2000;

    logic                        clk = 1'b0;
    logic                        rst = 1'b1;
    logic                        xfer_start = 1'b0;
    logic [`SPI_DMA_ADDR_W-1:0]  xfer_addr = '0;
    logic [`SPI_DMA_COUNT_W-1:0] xfer_count = '0;
    logic                        xfer_rx_only = 1'b0;
    logic                        xfer_busy;
    logic                        xfer_done;
    logic [`SPI_DMA_ADDR_W-1:0]  host_addr = '0;
    logic [`SPI_DMA_DATA_W-1:0]  host_wdata = '0;
    logic                        host_we = 1'b0;
    logic [`SPI_DMA_DATA_W-1:0]  host_rdata;
    logic                        sclk;
    logic                        mosi;
    logic                        cs_n;
    logic                        miso = 1'b0;

    logic [7:0] resp_q [$];
    logic [7:0] mosi_q [$];
    logic [7:0] load_data [16];
    logic [7:0] resp_data [16];
    logic [7:0] cur_resp = '0;
    logic [7:0] mosi_shift = '0;
    logic       miso_bit = 1'b0;
    logic       prev_cs_n = 1'b1;
    logic       prev_sclk = 1'b0;
    int         bit_cnt = 0;
    int         cs_fall_count = 0;
    int         done_count = 0;

    spi_dma_top i_dut
    (
        .clk_i          (clk),
        .rst_i          (rst),
        .xfer_start_i   (xfer_start),
        .xfer_addr_i    (xfer_addr),
        .xfer_count_i   (xfer_count),
        .xfer_rx_only_i (xfer_rx_only),
        .xfer_busy_o    (xfer_busy),
        .xfer_done_o    (xfer_done),
        .host_addr_i    (host_addr),
        .host_wdata_i   (host_wdata),
        .host_we_i      (host_we),
        .host_rdata_o   (host_rdata),
        .sclk_o         (sclk),
        .mosi_o         (mosi),
        .cs_n_o         (cs_n),
        .miso_i         (miso)
    );

    initial
    begin
        forever
        begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        miso <= miso_bit;
    end

    // SPI slave model and event counters
    always @(negedge clk)
    begin
        if (xfer_done)
            done_count++;
        if (prev_cs_n && !cs_n)
        begin
            cs_fall_count++;
            cur_resp = 8'h00;
            if (resp_q.size() > 0)
                cur_resp = resp_q.pop_front();
            bit_cnt  = 0;
            miso_bit = cur_resp[7];
        end
        if (!cs_n && !prev_sclk && sclk)
        begin
            mosi_shift = {mosi_shift[6:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8)
                mosi_q.push_back(mosi_shift);
        end
        // Next response bit goes out after each falling SCLK edge
        if (!cs_n && prev_sclk && !sclk && bit_cnt < 8)
            miso_bit = cur_resp[7 - bit_cnt];
        prev_cs_n = cs_n;
        prev_sclk = sclk;
    end

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp)
        else report_error($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
    endtask

    // Condition 0 waits for the done pulse, 1 for busy low and 2 for chip select low
    task automatic wait_until(input int cond, input int limit, input string what);
        int cycles;
        bit met;
        cycles = 0;
        met    = 1'b0;
        while (!met && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            met = (cond == 0) ? xfer_done : ((cond == 1) ? !xfer_busy : !cs_n);
        end
        if (!met)
        begin
            $display("Timeout: %s did not happen within %0d cycles", what, limit);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic write_byte(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        host_addr  <= addr;
        host_wdata <= data;
        host_we    <= 1'b1;
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic read_byte(input logic [7:0] addr, output logic [7:0] data);
        @(posedge clk);
        host_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = host_rdata;
    endtask

    task automatic prepare_data(input int n);
        int i;
        resp_q.delete();
        mosi_q.delete();
        for (i = 0; i < 16; i++)
        begin
            load_data[i] = 8'($urandom);
            resp_data[i] = 8'($urandom);
            if (i < n)
                resp_q.push_back(resp_data[i]);
        end
    endtask

    task automatic load_buffer(input logic [7:0] base, input int n);
        int i;
        for (i = 0; i < n; i++)
            write_byte(8'(base + i), load_data[i]);
    endtask

    task automatic start_transfer(input logic [7:0] addr, input logic [15:0] count, input bit rx);
        @(posedge clk);
        xfer_start   <= 1'b1;
        xfer_addr    <= addr;
        xfer_count   <= count;
        xfer_rx_only <= rx;
        @(posedge clk);
        xfer_start <= 1'b0;
    endtask

    // Busy is high from the edge that accepts the command
    task automatic run_transfer(input logic [7:0] addr, input logic [15:0] count, input bit rx);
        start_transfer(addr, count, rx);
        @(negedge clk);
        assert (xfer_busy) else report_error("xfer_busy_o did not rise after a start");
        wait_until(0, DONE_LIMIT, "xfer_done_o pulse");
        wait_until(1, 4, "xfer_busy_o release");
    endtask

    // MOSI bytes follow the buffer or are all ones, and the buffer then holds the responses
    task automatic check_results(input logic [7:0] base, input int n, input bit rx);
        logic [7:0] got;
        int         i;
        check_value(8'(mosi_q.size()), 8'(n), "number of MOSI bytes");
        for (i = 0; i < n; i++)
        begin
            check_value(mosi_q[i], rx ? 8'hFF : load_data[i], $sformatf("MOSI byte %0d", i));
            read_byte(8'(base + i), got);
            check_value(got, resp_data[i], $sformatf("buffer at 0x%02h", 8'(base + i)));
        end
    endtask

    task automatic address_wrap();
        logic [7:0] got;
        int         i;
        prepare_data(0);
        for (i = 0; i < 6; i++)
        begin
            resp_data[i] = 8'(i);
            resp_q.push_back(8'(i));
        end
        load_buffer(8'hFD, 7);
        run_transfer(8'hFD, 16'd6, 1'b0);
        check_results(8'hFD, 6, 1'b0);
        read_byte(8'h03, got);
        check_value(got, load_data[6], "untouched buffer at 0x03");
    endtask

    task automatic zero_count_ignored();
        logic [7:0] got;
        int         done_before;
        int         cs_before;
        int         i;
        prepare_data(0);
        load_buffer(8'h80, 4);
        done_before = done_count;
        cs_before   = cs_fall_count;
        start_transfer(8'h80, 16'd0, 1'b0);
        for (i = 0; i < 200; i++)
        begin
            @(negedge clk);
            assert (!xfer_busy) else report_error("xfer_busy_o rose on a zero count");
        end
        check_value(8'(done_count - done_before), 8'd0, "done pulses on a zero count");
        check_value(8'(cs_fall_count - cs_before), 8'd0, "chip selects on a zero count");
        for (i = 0; i < 4; i++)
        begin
            read_byte(8'(8'h80 + i), got);
            check_value(got, load_data[i], "buffer after a zero count");
        end
    endtask

    task automatic start_while_busy();
        logic [7:0] got;
        int         done_before;
        prepare_data(4);
        load_buffer(8'h60, 4);
        write_byte(8'h90, load_data[4]);
        write_byte(8'h91, load_data[5]);
        done_before = done_count;
        start_transfer(8'h60, 16'd4, 1'b0);
        wait_until(2, 20, "first chip select");
        start_transfer(8'h90, 16'd2, 1'b1);
        wait_until(0, DONE_LIMIT, "xfer_done_o pulse");
        wait_until(1, 4, "xfer_busy_o release");
        repeat (200) @(negedge clk);
        check_value(8'(done_count - done_before), 8'd1, "done pulses with a second start");
        check_results(8'h60, 4, 1'b0);
        read_byte(8'h90, got);
        check_value(got, load_data[4], "buffer at 0x90");
        read_byte(8'h91, got);
        check_value(got, load_data[5], "buffer at 0x91");
    endtask

    initial
    begin
        void'($urandom(27));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value({6'd0, cs_n, sclk}, 8'd2, "cs_n_o and sclk_o after reset");
        check_value({6'd0, xfer_busy, xfer_done}, 8'd0, "busy and done after reset");

        prepare_data(16);
        load_buffer(8'h20, 16);
        run_transfer(8'h20, 16'd16, 1'b0);
        check_results(8'h20, 16, 1'b0);

        prepare_data(8);
        load_buffer(8'h40, 8);
        run_transfer(8'h40, 16'd8, 1'b1);
        check_results(8'h40, 8, 1'b1);

        address_wrap();
        zero_count_ignored();
        start_while_busy();

        $display("sim passed");
        $finish;
    end

endmodule

//--- spi_dma_assert.sv
`timescale 1ns/1ns

module spi_dma_assert
(
    input logic clk_i,
    input logic rst_i,
    input logic busy_i,
    input logic done_i,
    input logic sclk_i,
    input logic cs_n_i
);

    done_pulse: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
        else $error("xfer_done_o stayed high for more than one cycle");

    // Chip select only moves inside a transfer
    cs_idle: assert property (@(posedge clk_i) disable iff (rst_i) !busy_i |-> cs_n_i)
        else $error("cs_n_o low while xfer_busy_o is low");

    sclk_idle: assert property (@(posedge clk_i) disable iff (rst_i) cs_n_i |-> !sclk_i)
        else $error("sclk_o high while cs_n_o is high");

    done_busy: assert property (@(posedge clk_i) disable iff (rst_i) done_i |-> busy_i)
        else $error("xfer_done_o pulsed outside a busy transfer");

endmodule

bind spi_dma_top spi_dma_assert i_assert
(
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .busy_i (xfer_busy_o),
    .done_i (xfer_done_o),
    .sclk_i (sclk_o),
    .cs_n_i (cs_n_o)
);

//--- spi_dma_top.sv
`timescale 1ns/1ns
`include "spi_dma_macros.svh"

module spi_dma_top
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        xfer_start_i,
    input  logic [`SPI_DMA_ADDR_W-1:0]  xfer_addr_i,
    input  logic [`SPI_DMA_COUNT_W-1:0] xfer_count_i,
    input  logic                        xfer_rx_only_i,
    output logic                        xfer_busy_o,
    output logic                        xfer_done_o,
    input  logic [`SPI_DMA_ADDR_W-1:0]  host_addr_i,
    input  logic [`SPI_DMA_DATA_W-1:0]  host_wdata_i,
    input  logic                        host_we_i,
    output logic [`SPI_DMA_DATA_W-1:0]  host_rdata_o,
    output logic                        sclk_o,
    output logic                        mosi_o,
    output logic                        cs_n_o,
    input  logic                        miso_i
);

    logic [`SPI_DMA_ADDR_W-1:0] mem_addr;
    logic [`SPI_DMA_DATA_W-1:0] mem_wdata;
    logic [`SPI_DMA_DATA_W-1:0] mem_rdata;
    logic                       mem_we;
    logic                       mem_rd;

    spi_xfer_if i_bus ();

    xfer_buf_ram i_ram
    (
        .clk_i        (clk_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_we_i    (host_we_i),
        .host_rdata_o (host_rdata_o),
        .eng_addr_i   (mem_addr),
        .eng_wdata_i  (mem_wdata),
        .eng_we_i     (mem_we),
        .eng_rd_i     (mem_rd),
        .eng_rdata_o  (mem_rdata)
    );

    spi_xfer_ctrl i_ctrl
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .xfer_start_i   (xfer_start_i),
        .xfer_addr_i    (xfer_addr_i),
        .xfer_count_i   (xfer_count_i),
        .xfer_rx_only_i (xfer_rx_only_i),
        .xfer_busy_o    (xfer_busy_o),
        .xfer_done_o    (xfer_done_o),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata),
        .mem_we_o       (mem_we),
        .mem_rd_o       (mem_rd),
        .mem_rdata_i    (mem_rdata),
        .bus            (i_bus.ctrl)
    );

    spi_master i_master
    (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .bus    (i_bus.master),
        .sclk_o (sclk_o),
        .mosi_o (mosi_o),
        .cs_n_o (cs_n_o),
        .miso_i (miso_i)
    );

endmodule

//--- spi_xfer_ctrl.sv
`timescale 1ns/1ns
`include "spi_dma_macros.svh"

module spi_xfer_ctrl
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        xfer_start_i,
    input  logic [`SPI_DMA_ADDR_W-1:0]  xfer_addr_i,
    input  logic [`SPI_DMA_COUNT_W-1:0] xfer_count_i,
    input  logic                        xfer_rx_only_i,
    output logic                        xfer_busy_o,
    output logic                        xfer_done_o,
    output logic [`SPI_DMA_ADDR_W-1:0]  mem_addr_o,
    output logic [`SPI_DMA_DATA_W-1:0]  mem_wdata_o,
    output logic                        mem_we_o,
    output logic                        mem_rd_o,
    input  logic [`SPI_DMA_DATA_W-1:0]  mem_rdata_i,
    spi_xfer_if.ctrl                    bus
);

    spi_dma_pkg::xfer_state_e    state_q;
    logic [`SPI_DMA_COUNT_W-1:0] count_q;
    logic [`SPI_DMA_COUNT_W-1:0] current_q;
    logic [`SPI_DMA_ADDR_W-1:0]  addr_q;
    logic                        rx_only_q;
    logic                        accept;
    logic                        byte_done;
    logic                        last_byte;

    // Commands are only looked at in IDLE, a zero count is dropped
    assign accept    = (state_q == spi_dma_pkg::XFER_IDLE) && xfer_start_i &&
                       (xfer_count_i != '0);
    assign byte_done = (state_q == spi_dma_pkg::XFER_WAIT_DONE) && bus.done;
    assign last_byte = (current_q == count_q);

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q     <= spi_dma_pkg::XFER_IDLE;
            xfer_busy_o <= 1'b0;
            xfer_done_o <= 1'b0;
            mem_rd_o    <= 1'b0;
            mem_we_o    <= 1'b0;
            bus.start   <= 1'b0;
        end
        else
        begin
            xfer_done_o <= 1'b0;
            mem_rd_o    <= 1'b0;
            mem_we_o    <= 1'b0;
            bus.start   <= 1'b0;

            case (state_q)
            spi_dma_pkg::XFER_IDLE:
            begin
                // Busy drops here, one cycle after the done pulse
                xfer_busy_o <= accept;
                if (accept)
                begin
                    state_q <= spi_dma_pkg::XFER_READ;
                end
            end
            spi_dma_pkg::XFER_READ:
            begin
                mem_rd_o <= 1'b1;
                state_q  <= spi_dma_pkg::XFER_READ_WAIT;
            end
            spi_dma_pkg::XFER_READ_WAIT:
            begin
                state_q <= spi_dma_pkg::XFER_XFER;
            end
            spi_dma_pkg::XFER_XFER:
            begin
                bus.start <= 1'b1;
                state_q   <= spi_dma_pkg::XFER_WAIT_DONE;
            end
            spi_dma_pkg::XFER_WAIT_DONE:
            begin
                if (bus.done)
                begin
                    mem_we_o <= 1'b1;
                    if (last_byte)
                    begin
                        xfer_done_o <= 1'b1;
                        state_q     <= spi_dma_pkg::XFER_IDLE;
                    end
                    else
                    begin
                        state_q <= spi_dma_pkg::XFER_READ;
                    end
                end
            end
            default:
            begin
                state_q <= spi_dma_pkg::XFER_IDLE;
            end
            endcase
        end
    end

    // Command registers and datapath
    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            count_q   <= xfer_count_i;
            current_q <= `SPI_DMA_COUNT_W'(1);
            addr_q    <= xfer_addr_i;
            rx_only_q <= xfer_rx_only_i;
        end

        // The address set here also serves the write-back of the same byte
        if (state_q == spi_dma_pkg::XFER_READ)
        begin
            mem_addr_o <= addr_q;
        end

        // Receive-only sends all ones and ignores the buffer contents
        if (state_q == spi_dma_pkg::XFER_XFER)
        begin
            bus.tx_data <= rx_only_q ? {`SPI_DMA_DATA_W{1'b1}} : mem_rdata_i;
        end

        if (byte_done)
        begin
            mem_wdata_o <= bus.rx_data;
            if (!last_byte)
            begin
                addr_q    <= addr_q + 1'b1;
                current_q <= current_q + 1'b1;
            end
        end
    end

endmodule

//--- spi_master.sv
`timescale 1ns/1ns
`include "spi_dma_macros.svh"

module spi_master
(
    input  logic       clk_i,
    input  logic       rst_i,
    spi_xfer_if.master bus,
    output logic       sclk_o,
    output logic       mosi_o,
    output logic       cs_n_o,
    input  logic       miso_i
);

    localparam int DIV_W  = $clog2(`SPI_DMA_CLK_DIV + 1);
    localparam int BIT_W  = $clog2(`SPI_DMA_DATA_W);
    localparam int DATA_W = `SPI_DMA_DATA_W;

    spi_dma_pkg::spi_state_e state_q;
    logic [DIV_W-1:0]        div_q;
    logic [BIT_W-1:0]        bit_q;
    logic [DATA_W-1:0]       tx_shift_q;
    logic [DATA_W-1:0]       rx_shift_q;
    logic                    div_last;
    logic                    sclk_rise;
    logic                    sclk_fall;
    logic                    byte_end;

    assign div_last  = (div_q == DIV_W'(`SPI_DMA_CLK_DIV - 1));
    assign sclk_rise = div_last && ((state_q == spi_dma_pkg::SPI_SETUP) ||
                                    (state_q == spi_dma_pkg::SPI_LOW));
    assign sclk_fall = div_last && (state_q == spi_dma_pkg::SPI_HIGH);
    assign byte_end  = div_last && (state_q == spi_dma_pkg::SPI_FINISH);

    // MSB first, MOSI is valid as soon as chip select falls
    assign mosi_o = tx_shift_q[DATA_W-1];

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q  <= spi_dma_pkg::SPI_IDLE;
            div_q    <= '0;
            bit_q    <= '0;
            sclk_o   <= 1'b0;
            cs_n_o   <= 1'b1;
            bus.done <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;

            // Divider runs through every half period and rests in IDLE
            if ((state_q == spi_dma_pkg::SPI_IDLE) || div_last)
            begin
                div_q <= '0;
            end
            else
            begin
                div_q <= div_q + 1'b1;
            end

            case (state_q)
            spi_dma_pkg::SPI_IDLE:
            begin
                bit_q <= '0;
                if (bus.start)
                begin
                    cs_n_o  <= 1'b0;
                    state_q <= spi_dma_pkg::SPI_SETUP;
                end
            end
            spi_dma_pkg::SPI_SETUP,
            spi_dma_pkg::SPI_LOW:
            begin
                if (div_last)
                begin
                    sclk_o  <= 1'b1;
                    state_q <= spi_dma_pkg::SPI_HIGH;
                end
            end
            spi_dma_pkg::SPI_HIGH:
            begin
                if (div_last)
                begin
                    sclk_o <= 1'b0;
                    if (bit_q == BIT_W'(DATA_W - 1))
                    begin
                        state_q <= spi_dma_pkg::SPI_FINISH;
                    end
                    else
                    begin
                        bit_q   <= bit_q + 1'b1;
                        state_q <= spi_dma_pkg::SPI_LOW;
                    end
                end
            end
            spi_dma_pkg::SPI_FINISH:
            begin
                // Half a period of hold after the last falling edge
                if (div_last)
                begin
                    cs_n_o   <= 1'b1;
                    bus.done <= 1'b1;
                    state_q  <= spi_dma_pkg::SPI_IDLE;
                end
            end
            default:
            begin
                state_q <= spi_dma_pkg::SPI_IDLE;
            end
            endcase
        end
    end

    // Shift registers carry payload only
    always_ff @(posedge clk_i)
    begin
        if ((state_q == spi_dma_pkg::SPI_IDLE) && bus.start)
        begin
            tx_shift_q <= bus.tx_data;
        end
        else if (sclk_fall)
        begin
            tx_shift_q <= {tx_shift_q[DATA_W-2:0], 1'b0};
        end

        if (sclk_rise)
        begin
            rx_shift_q <= {rx_shift_q[DATA_W-2:0], miso_i};
        end

        if (byte_end)
        begin
            bus.rx_data <= rx_shift_q;
        end
    end

endmodule

//--- xfer_buf_ram.sv
`timescale 1ns/1ns
`include "spi_dma_macros.svh"

module xfer_buf_ram
(
    input  logic                       clk_i,
    input  logic [`SPI_DMA_ADDR_W-1:0] host_addr_i,
    input  logic [`SPI_DMA_DATA_W-1:0] host_wdata_i,
    input  logic                       host_we_i,
    output logic [`SPI_DMA_DATA_W-1:0] host_rdata_o,
    input  logic [`SPI_DMA_ADDR_W-1:0] eng_addr_i,
    input  logic [`SPI_DMA_DATA_W-1:0] eng_wdata_i,
    input  logic                       eng_we_i,
    input  logic                       eng_rd_i,
    output logic [`SPI_DMA_DATA_W-1:0] eng_rdata_o
);

    logic [`SPI_DMA_DATA_W-1:0] mem [2**`SPI_DMA_ADDR_W];

    // The host never writes while the engine is busy, so the two write
    // ports do not collide in normal use
    always_ff @(posedge clk_i)
    begin
        if (host_we_i)
        begin
            mem[host_addr_i] <= host_wdata_i;
        end
        if (eng_we_i)
        begin
            mem[eng_addr_i] <= eng_wdata_i;
        end
    end

    // Host reads every cycle
    always_ff @(posedge clk_i)
    begin
        host_rdata_o <= mem[host_addr_i];
    end

    // Engine read data holds until the next read strobe
    always_ff @(posedge clk_i)
    begin
        if (eng_rd_i)
        begin
            eng_rdata_o <= mem[eng_addr_i];
        end
    end

endmodule

//--- spi_xfer_if.sv
`timescale 1ns/1ns
`include "spi_dma_macros.svh"

// Byte exchange between the transfer controller and the SPI master
interface spi_xfer_if;

    logic                       start;
    logic [`SPI_DMA_DATA_W-1:0] tx_data;
    logic [`SPI_DMA_DATA_W-1:0] rx_data;
    logic                       done;

    modport ctrl
    (
        output start,
        output tx_data,
        input  rx_data,
        input  done
    );

    modport master
    (
        input  start,
        input  tx_data,
        output rx_data,
        output done
    );

endinterface

//--- spi_dma_pkg.sv
package spi_dma_pkg;

    // Transfer controller states, one buffer byte per pass from READ to WAIT_DONE
    typedef enum logic [2:0]
    {
        XFER_IDLE      = 3'd0,
        XFER_READ      = 3'd1,
        XFER_READ_WAIT = 3'd2,
        XFER_XFER      = 3'd3,
        XFER_WAIT_DONE = 3'd4
    } xfer_state_e;

    // SPI master states
    // SETUP is the first low half period after chip select falls
    typedef enum logic [2:0]
    {
        SPI_IDLE   = 3'd0,
        SPI_SETUP  = 3'd1,
        SPI_LOW    = 3'd2,
        SPI_HIGH   = 3'd3,
        SPI_FINISH = 3'd4
    } spi_state_e;

endpackage

//--- spi_dma_macros.svh
`ifndef SPI_DMA_MACROS_SVH
`define SPI_DMA_MACROS_SVH

// Buffer address width, 256 bytes with wrap-around addressing
`define SPI_DMA_ADDR_W 8

// One transfer unit is a byte
`define SPI_DMA_DATA_W 8

// Width of the byte count of one command
`define SPI_DMA_COUNT_W 16

// System clocks per SCLK half period
`define SPI_DMA_CLK_DIV 2

`endif
